// ==== Bender.yml ====
package:
  name: pcie_trans

sources:
  # package first, leaf modules, then the top
  - rtl/pcie_trans_pkg.sv
  - rtl/flow_fifo.sv
  - rtl/vc_steer.sv
  - rtl/vc_arbiter.sv
  - rtl/link_ctrl_fsm.sv
  - rtl/pcie_trans.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/pcie_trans_tb.sv

// ==== compile.f ====
rtl/pcie_trans_pkg.sv
rtl/flow_fifo.sv
rtl/vc_steer.sv
rtl/vc_arbiter.sv
rtl/link_ctrl_fsm.sv
rtl/pcie_trans.sv
sim/clk_gen.sv
sim/pcie_trans_tb.sv

// ==== rtl/flow_fifo.sv ====
//##########################################################
// show-ahead packet FIFO with almost-full pause
// and overflow pulse on a push into a full buffer
//##########################################################
`timescale 1ns/10ps
`default_nettype none

module flow_fifo import pcie_trans_pkg::*; #(
	parameter int DEPTH = 4
) (
	input  logic             clk,
	input  logic             reset_L,
	input  logic             push,
	input  logic             pop,
	input  pkt_t             din,
	input  logic [CNT_W-1:0] af_level,
	output pkt_t             dout,
	output logic             empty,
	output logic             full,
	output logic             pause,
	output logic             overflow
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// packet storage
	pkt_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             wr_en;
	logic             rd_en;

	// a word pushed while full is dropped
	assign wr_en = push && !full;
	// pop on empty is ignored
	assign rd_en = pop && !empty;

	assign empty    = (count == '0);
	assign full     = (count == CNT_W'(DEPTH));
	assign pause    = (count >= af_level);
	assign overflow = push && full;

	// head visible while not empty
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= din;
		end
	end

	// pointers and fill count
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				// wrap at depth, also for non power of two
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// the reader upstream must watch the empty flag
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_L)
		!(pop && empty));

endmodule

`default_nettype wire

// ==== rtl/link_ctrl_fsm.sv ====
//##########################################################
// link control FSM, threshold register, ingress gate
//##########################################################
`timescale 1ns/10ps
`default_nettype none

module link_ctrl_fsm import pcie_trans_pkg::*; (
	input  logic        clk,
	input  logic        reset_L,
	input  logic        init,
	input  thresh_cfg_t cfg,
	input  logic        push,
	input  logic        any_nonempty,
	input  logic        any_overflow,
	output thresh_cfg_t thresh,
	output logic        push_ok,
	output logic        idle,
	output logic        active,
	output logic        error
);

	link_state_t state;
	link_state_t state_nx;

	// ingress only while the link is up
	assign push_ok = push && (state == IDLE || state == ACTIVE);

	always_comb begin
		state_nx = state;
		case (state)
			RESET:  state_nx = INIT;
			INIT:   state_nx = init ? INIT : IDLE;
			IDLE:   if (push_ok || any_nonempty) state_nx = ACTIVE;
			// back to idle once every fifo drained
			ACTIVE: if (!push_ok && !any_nonempty) state_nx = IDLE;
			// sticky until reset
			ERROR:  state_nx = ERROR;
			default: state_nx = RESET;
		endcase
		// overflow anywhere wins
		if (any_overflow) begin
			state_nx = ERROR;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_L) begin
			state <= RESET;
		end else begin
			state <= state_nx;
		end
	end

	// all ones keeps pause low until configured
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			thresh <= '1;
		end else if (state == INIT) begin
			thresh <= cfg;
		end
	end

	// status decode
	assign idle   = (state == IDLE);
	assign active = (state == ACTIVE);
	assign error  = (state == ERROR);

	a_status_onehot: assert property (@(posedge clk) disable iff (!reset_L)
		$onehot0({idle, active, error}));

endmodule

`default_nettype wire

// ==== rtl/pcie_trans.sv ====
//##########################################################
// two-channel transaction layer top
// main, VC and destination FIFOs with steering and control
//##########################################################
`timescale 1ns/10ps
`default_nettype none

module pcie_trans import pcie_trans_pkg::*; #(
	parameter int MAIN_DEPTH = 4,
	parameter int VC_DEPTH   = 16,
	parameter int DEST_DEPTH = 4
) (
	input  logic        clk,
	input  logic        reset_L,
	input  logic        init,
	input  thresh_cfg_t cfg,
	input  pkt_t        in_pkt,
	input  logic        push,
	input  logic        pop_d0,
	input  logic        pop_d1,
	output pkt_t        out_pkt0,
	output pkt_t        out_pkt1,
	output logic        out_valid0,
	output logic        out_valid1,
	output logic        pause_main,
	output logic        idle,
	output logic        active,
	output logic        error
);

	thresh_cfg_t thresh;
	logic        push_ok;

	// main fifo side
	pkt_t main_head;
	logic main_empty, main_pop, main_ovf;

	// vc stage
	pkt_t vc_pkt, vc0_head, vc1_head;
	logic push_vc0, push_vc1, pop_vc0, pop_vc1;
	logic vc0_empty, vc1_empty, pause_vc0, pause_vc1, vc0_ovf, vc1_ovf;

	// destination stage
	pkt_t dest_pkt;
	logic push_d0, push_d1, d0_empty, d1_empty;
	logic pause_d0, pause_d1, d0_ovf, d1_ovf;

	logic any_nonempty, any_overflow;

	assign any_nonempty = !(main_empty && vc0_empty && vc1_empty && d0_empty && d1_empty);
	assign any_overflow = main_ovf || vc0_ovf || vc1_ovf || d0_ovf || d1_ovf;

	// consumer sees the head whenever the fifo holds one
	assign out_valid0 = !d0_empty;
	assign out_valid1 = !d1_empty;

	link_ctrl_fsm link_ctrl_fsm_inst (
		.clk(clk), .reset_L(reset_L), .init(init), .cfg(cfg), .push(push),
		.any_nonempty(any_nonempty), .any_overflow(any_overflow), .thresh(thresh),
		.push_ok(push_ok), .idle(idle), .active(active), .error(error)
	);

	flow_fifo #(.DEPTH(MAIN_DEPTH)) main_fifo (
		.clk(clk), .reset_L(reset_L), .push(push_ok), .pop(main_pop), .din(in_pkt),
		.af_level(thresh.main_af), .dout(main_head), .empty(main_empty), .full(),
		.pause(pause_main), .overflow(main_ovf)
	);

	vc_steer vc_steer_inst (
		.clk(clk), .reset_L(reset_L), .head(main_head), .head_empty(main_empty),
		.pause_vc0(pause_vc0), .pause_vc1(pause_vc1), .pop(main_pop),
		.vc_pkt(vc_pkt), .push_vc0(push_vc0), .push_vc1(push_vc1)
	);

	flow_fifo #(.DEPTH(VC_DEPTH)) vc0_fifo (
		.clk(clk), .reset_L(reset_L), .push(push_vc0), .pop(pop_vc0), .din(vc_pkt),
		.af_level(thresh.vc0_af), .dout(vc0_head), .empty(vc0_empty), .full(),
		.pause(pause_vc0), .overflow(vc0_ovf)
	);

	flow_fifo #(.DEPTH(VC_DEPTH)) vc1_fifo (
		.clk(clk), .reset_L(reset_L), .push(push_vc1), .pop(pop_vc1), .din(vc_pkt),
		.af_level(thresh.vc1_af), .dout(vc1_head), .empty(vc1_empty), .full(),
		.pause(pause_vc1), .overflow(vc1_ovf)
	);

	vc_arbiter vc_arbiter_inst (
		.clk(clk), .reset_L(reset_L), .vc0_head(vc0_head), .vc0_empty(vc0_empty),
		.vc1_head(vc1_head), .vc1_empty(vc1_empty), .pause_d0(pause_d0),
		.pause_d1(pause_d1), .pop_vc0(pop_vc0), .pop_vc1(pop_vc1),
		.dest_pkt(dest_pkt), .push_d0(push_d0), .push_d1(push_d1)
	);

	// consumer pop only takes effect on a valid head
	flow_fifo #(.DEPTH(DEST_DEPTH)) d0_fifo (
		.clk(clk), .reset_L(reset_L), .push(push_d0), .pop(pop_d0 && out_valid0),
		.din(dest_pkt), .af_level(thresh.d0_af), .dout(out_pkt0), .empty(d0_empty),
		.full(), .pause(pause_d0), .overflow(d0_ovf)
	);

	flow_fifo #(.DEPTH(DEST_DEPTH)) d1_fifo (
		.clk(clk), .reset_L(reset_L), .push(push_d1), .pop(pop_d1 && out_valid1),
		.din(dest_pkt), .af_level(thresh.d1_af), .dout(out_pkt1), .empty(d1_empty),
		.full(), .pause(pause_d1), .overflow(d1_ovf)
	);

endmodule

`default_nettype wire

// ==== rtl/pcie_trans_pkg.sv ====
//##########################################################
// shared types of the two-channel transaction layer
// packet layout, threshold set, link states and widths
//##########################################################
`default_nettype none

package pcie_trans_pkg;

	// fill count / threshold width, enough for depth 16
	localparam int CNT_W = 5;

	// payload width inside a packet
	localparam int DATA_W = 4;

	// six-bit packet, vc on top, then dest, then payload
	typedef struct packed {
		// 0 selects VC0
		logic              vc;
		// 0 selects D0
		logic              dest;
		logic [DATA_W-1:0] data;
	} pkt_t;

	// almost-full levels, one per fifo
	typedef struct packed {
		logic [CNT_W-1:0] main_af;
		logic [CNT_W-1:0] vc0_af;
		logic [CNT_W-1:0] vc1_af;
		logic [CNT_W-1:0] d0_af;
		logic [CNT_W-1:0] d1_af;
	} thresh_cfg_t;

	// link control states
	typedef enum logic [2:0] {
		RESET  = 3'd0,
		INIT   = 3'd1,
		IDLE   = 3'd2,
		ACTIVE = 3'd3,
		ERROR  = 3'd4
	} link_state_t;

endpackage

`default_nettype wire

// ==== rtl/vc_arbiter.sv ====
//##########################################################
// strict VC0-priority arbiter feeding the D0/D1 FIFOs
//##########################################################
`timescale 1ns/10ps
`default_nettype none

module vc_arbiter import pcie_trans_pkg::*; (
	input  logic clk,
	input  logic reset_L,
	input  pkt_t vc0_head,
	input  logic vc0_empty,
	input  pkt_t vc1_head,
	input  logic vc1_empty,
	input  logic pause_d0,
	input  logic pause_d1,
	output logic pop_vc0,
	output logic pop_vc1,
	output pkt_t dest_pkt,
	output logic push_d0,
	output logic push_d1
);

	logic dest_ready;
	logic grant;
	pkt_t sel_pkt;

	// any paused destination stalls both vcs
	assign dest_ready = !pause_d0 && !pause_d1;

	// vc0 always wins
	assign pop_vc0 = dest_ready && !vc0_empty;
	// vc1 only when vc0 has nothing
	assign pop_vc1 = dest_ready && vc0_empty && !vc1_empty;

	assign grant   = pop_vc0 || pop_vc1;
	assign sel_pkt = pop_vc0 ? vc0_head : vc1_head;

	// payload register
	always_ff @(posedge clk) begin
		if (grant) begin
			dest_pkt <= sel_pkt;
		end
	end

	// destination push one cycle after the vc pop
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			push_d0 <= 1'b0;
			push_d1 <= 1'b0;
		end else begin
			push_d0 <= grant && !sel_pkt.dest;
			push_d1 <= grant && sel_pkt.dest;
		end
	end

	a_single_grant: assert property (@(posedge clk) disable iff (!reset_L)
		!(pop_vc0 && pop_vc1));

endmodule

`default_nettype wire

// ==== rtl/vc_steer.sv ====
//##########################################################
// moves main-FIFO packets into VC0 or VC1 by the vc bit
//##########################################################
`timescale 1ns/10ps
`default_nettype none

module vc_steer import pcie_trans_pkg::*; (
	input  logic clk,
	input  logic reset_L,
	input  pkt_t head,
	input  logic head_empty,
	input  logic pause_vc0,
	input  logic pause_vc1,
	output logic pop,
	output pkt_t vc_pkt,
	output logic push_vc0,
	output logic push_vc1
);

	logic target_paused;

	// only the pause of the head's own vc matters
	assign target_paused = head.vc ? pause_vc1 : pause_vc0;

	// head leaves main fifo this cycle
	assign pop = !head_empty && !target_paused;

	// packet register toward the vc fifos
	always_ff @(posedge clk) begin
		if (pop) begin
			vc_pkt <= head;
		end
	end

	// vc write one cycle after the pop
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			push_vc0 <= 1'b0;
			push_vc1 <= 1'b0;
		end else begin
			push_vc0 <= pop && !head.vc;
			push_vc1 <= pop && head.vc;
		end
	end

	a_one_vc: assert property (@(posedge clk) disable iff (!reset_L)
		!(push_vc0 && push_vc1));

endmodule

`default_nettype wire

// ==== sim/clk_gen.sv ====
//##########################################################
// testbench clock and reset source
//##########################################################
`timescale 1ns/10ps
`default_nettype none

module clk_gen #(
	parameter int PERIOD       = 10,
	parameter int RESET_CYCLES = 2
) (
	input  logic reset_req,
	output logic clk,
	output logic reset_L
);

	logic por_done;

	// free running clock
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// power-on reset, released just after an edge
	initial begin
		por_done = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 por_done = 1'b1;
	end

	// later resets come from the test sequence
	assign reset_L = por_done && !reset_req;

endmodule

`default_nettype wire

// ==== sim/pcie_trans_tb.sv ====
//##########################################################
// directed tests for the two-channel transaction layer
//##########################################################
`timescale 1ns/10ps
`default_nettype none

module pcie_trans_tb import pcie_trans_pkg::*; ();

	localparam int CLK_PERIOD = 10;
	localparam int MAIN_DEPTH = 4;
	localparam int VC_DEPTH   = 16;
	localparam int DEST_DEPTH = 4;

	// packets per test
	localparam int ROUTE_N = 40;
	localparam int BP_N    = 30;
	localparam int TH_N    = 20;
	localparam int ERR_N   = 40;
	// the single threshold packet and the refused pushes count too
	localparam int TOTAL_PKTS      = ROUTE_N + BP_N + TH_N + 1 + ERR_N + 4;
	localparam int WATCHDOG_CYCLES = 20 * TOTAL_PKTS + 500;
	localparam int DRAIN_LIMIT     = 200;
	// long enough for a packet to cross all three stages
	localparam int QUIET_CYCLES    = 20;

	logic        clk, reset_L, reset_req;
	logic        init, push, pop_d0, pop_d1;
	thresh_cfg_t cfg;
	pkt_t        in_pkt, out_pkt0, out_pkt1;
	logic        out_valid0, out_valid1, pause_main, idle, active, error;

	// expected packets, one queue per vc and destination
	pkt_t q_v0_d0[$];
	pkt_t q_v0_d1[$];
	pkt_t q_v1_d0[$];
	pkt_t q_v1_d1[$];

	integer seed = 62;
	int     err_count = 0;
	int     pass_tests = 0;
	int     fail_tests = 0;
	string  cur_test = "none";
	bit     seen_pause;
	pkt_t   last_accepted;

	clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(2)) clk_gen_inst (
		.reset_req(reset_req), .clk(clk), .reset_L(reset_L)
	);

	pcie_trans #(
		.MAIN_DEPTH(MAIN_DEPTH), .VC_DEPTH(VC_DEPTH), .DEST_DEPTH(DEST_DEPTH)
	) pcie_trans_inst (
		.clk(clk), .reset_L(reset_L), .init(init), .cfg(cfg), .in_pkt(in_pkt),
		.push(push), .pop_d0(pop_d0), .pop_d1(pop_d1), .out_pkt0(out_pkt0),
		.out_pkt1(out_pkt1), .out_valid0(out_valid0), .out_valid1(out_valid1),
		.pause_main(pause_main), .idle(idle), .active(active), .error(error)
	);

	// vc and dest thresholds fixed, main level per test
	function automatic thresh_cfg_t make_cfg(input logic [CNT_W-1:0] main_af);
		make_cfg = '{main_af: main_af, vc0_af: 5'd8, vc1_af: 5'd8, d0_af: 5'd2, d1_af: 5'd2};
	endfunction

	function automatic int queued_total();
		return q_v0_d0.size() + q_v0_d1.size() + q_v1_d0.size() + q_v1_d1.size();
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic report_error(input string msg);
		err_count++;
		$display("error in %s: %s", cur_test, msg);
	endtask

	task automatic compare_pkt(input pkt_t exp, input pkt_t act);
		if (act !== exp) begin
			err_count++;
			$display("mismatch in %s: expected vc=%0d dest=%0d data=%h, actual vc=%0d dest=%0d data=%h",
				cur_test, exp.vc, exp.dest, exp.data, act.vc, act.dest, act.data);
		end
	endtask

	// idle/active/error decode of a link state
	task automatic compare_state(input link_state_t exp);
		logic [2:0] exp_flags;
		exp_flags = {exp == IDLE, exp == ACTIVE, exp == ERROR};
		if ({idle, active, error} !== exp_flags) begin
			err_count++;
			$display("mismatch in %s: state %s expects idle/active/error %b, actual %b",
				cur_test, exp.name(), exp_flags, {idle, active, error});
		end
	endtask

	task automatic compare_flag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			err_count++;
			$display("mismatch in %s: %s expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic add_expected(input pkt_t p);
		case ({p.vc, p.dest})
			2'b00: q_v0_d0.push_back(p);
			2'b01: q_v0_d1.push_back(p);
			2'b10: q_v1_d0.push_back(p);
			default: q_v1_d1.push_back(p);
		endcase
	endtask

	// the word lost on overflow is the newest of its queue
	task automatic drop_expected(input pkt_t p);
		case ({p.vc, p.dest})
			2'b00: q_v0_d0.delete(q_v0_d0.size() - 1);
			2'b01: q_v0_d1.delete(q_v0_d1.size() - 1);
			2'b10: q_v1_d0.delete(q_v1_d0.size() - 1);
			default: q_v1_d1.delete(q_v1_d1.size() - 1);
		endcase
	endtask

	task automatic take_expected(input logic vc, input logic dest, output bit found,
		output pkt_t p);
		p = '0;
		case ({vc, dest})
			2'b00: found = (q_v0_d0.size() != 0);
			2'b01: found = (q_v0_d1.size() != 0);
			2'b10: found = (q_v1_d0.size() != 0);
			default: found = (q_v1_d1.size() != 0);
		endcase
		if (found) begin
			case ({vc, dest})
				2'b00: p = q_v0_d0.pop_front();
				2'b01: p = q_v0_d1.pop_front();
				2'b10: p = q_v1_d0.pop_front();
				default: p = q_v1_d1.pop_front();
			endcase
		end
	endtask

	task automatic check_output(input logic port, input pkt_t p);
		bit   found;
		pkt_t exp;
		if (p.dest !== port) begin
			report_error($sformatf("packet for D%0d came out on D%0d", p.dest, port));
		end else begin
			take_expected(p.vc, port, found, exp);
			if (!found)
				report_error($sformatf("unexpected packet %h on D%0d", p, port));
			else
				compare_pkt(exp, p);
		end
	endtask

	// consumer side, sampled mid-cycle where outputs are settled
	always @(negedge clk) begin
		if (reset_L) begin
			if (out_valid0 && pop_d0)
				check_output(1'b0, out_pkt0);
			if (out_valid1 && pop_d1)
				check_output(1'b1, out_pkt1);
		end
	end

	// random packets, one attempt per cycle
	task automatic send_packets(input int n, input bit honor_pause, input int max_cycles,
		output int sent);
		int          cycles;
		logic [31:0] r;
		pkt_t        p;
		sent = 0;
		cycles = 0;
		while (sent < n && cycles < max_cycles) begin
			if (pause_main)
				seen_pause = 1'b1;
			if (honor_pause && pause_main) begin
				push = 1'b0;
			end else begin
				r = $random(seed);
				p = r[5:0];
				in_pkt = p;
				push = 1'b1;
				sent++;
				// ingress only taken while the link is up
				if (idle || active) begin
					add_expected(p);
					last_accepted = p;
				end
			end
			step();
			cycles++;
		end
		push = 1'b0;
	endtask

	// wait for the scoreboard and both outputs to empty
	task automatic wait_drained(input link_state_t exp_state);
		int cycles;
		cycles = 0;
		while ((queued_total() != 0 || out_valid0 || out_valid1) && cycles < DRAIN_LIMIT) begin
			step();
			cycles++;
		end
		if (cycles >= DRAIN_LIMIT)
			report_error($sformatf("%0d packets still outstanding", queued_total()));
		repeat (2) step();
		compare_state(exp_state);
	endtask

	// nothing may reach an output once the scoreboard is empty
	task automatic expect_no_output(input int cycles);
		int i;
		bit seen;
		seen = 1'b0;
		for (i = 0; i < cycles; i++) begin
			if (out_valid0 || out_valid1)
				seen = 1'b1;
			step();
		end
		if (seen)
			report_error("a refused push still reached an output");
	endtask

	// init held over the INIT state, cfg loaded there
	task automatic init_link(input thresh_cfg_t c);
		init = 1'b1;
		cfg = c;
		step();
		compare_state(INIT);
		repeat (2) step();
		init = 1'b0;
		repeat (2) step();
		compare_state(IDLE);
	endtask

	task automatic apply_reset();
		push = 1'b0;
		pop_d0 = 1'b0;
		pop_d1 = 1'b0;
		reset_req = 1'b1;
		repeat (2) step();
		reset_req = 1'b0;
		q_v0_d0.delete();
		q_v0_d1.delete();
		q_v1_d0.delete();
		q_v1_d1.delete();
	endtask

	task automatic finish_test(input int start_err);
		if (err_count == start_err) begin
			pass_tests++;
			$display("test %s: done, no errors", cur_test);
		end else begin
			fail_tests++;
			$display("test %s: done, %0d errors", cur_test, err_count - start_err);
		end
	endtask

	task automatic link_up_test();
		int start_err;
		cur_test = "link_up";
		start_err = err_count;
		wait (reset_L === 1'b1);
		init_link(make_cfg(5'd3));
		finish_test(start_err);
	endtask

	task automatic routing_test();
		int start_err;
		int sent;
		cur_test = "routing";
		start_err = err_count;
		pop_d0 = 1'b1;
		pop_d1 = 1'b1;
		send_packets(ROUTE_N, 1'b1, ROUTE_N * 4, sent);
		if (sent != ROUTE_N)
			report_error("not all packets could be pushed");
		// last push just landed in main
		compare_state(ACTIVE);
		wait_drained(IDLE);
		finish_test(start_err);
	endtask

	task automatic backpressure_test();
		int start_err;
		int sent;
		cur_test = "backpressure";
		start_err = err_count;
		seen_pause = 1'b0;
		pop_d0 = 1'b0;
		pop_d1 = 1'b0;
		send_packets(BP_N, 1'b1, BP_N * 3, sent);
		compare_flag("pause_main seen", 1'b1, seen_pause);
		compare_flag("error", 1'b0, error);
		pop_d0 = 1'b1;
		pop_d1 = 1'b1;
		wait_drained(IDLE);
		finish_test(start_err);
	endtask

	task automatic threshold_test();
		int start_err;
		int sent;
		cur_test = "threshold";
		start_err = err_count;
		apply_reset();
		init_link(make_cfg(5'd1));
		// one packet in main, well below MAIN_DEPTH
		send_packets(1, 1'b1, 4, sent);
		compare_flag("pause_main after one packet", 1'b1, pause_main);
		send_packets(TH_N, 1'b1, TH_N * 4, sent);
		compare_flag("error", 1'b0, error);
		pop_d0 = 1'b1;
		pop_d1 = 1'b1;
		wait_drained(IDLE);
		finish_test(start_err);
	endtask

	task automatic error_test();
		int start_err;
		int sent;
		int i;
		cur_test = "error";
		start_err = err_count;
		pop_d0 = 1'b0;
		pop_d1 = 1'b0;
		// pause ignored until main overflows
		for (i = 0; i < ERR_N && !error; i++)
			send_packets(1, 1'b0, 1, sent);
		compare_flag("error raised", 1'b1, error);
		compare_state(ERROR);
		if (error)
			drop_expected(last_accepted);
		// refused by the link, so none of these is expected
		send_packets(4, 1'b0, 4, sent);
		pop_d0 = 1'b1;
		pop_d1 = 1'b1;
		wait_drained(ERROR);
		expect_no_output(QUIET_CYCLES);
		apply_reset();
		init_link(make_cfg(5'd3));
		finish_test(start_err);
	endtask

	initial begin
		reset_req = 1'b0;
		init = 1'b1;
		cfg = make_cfg(5'd3);
		in_pkt = '0;
		push = 1'b0;
		pop_d0 = 1'b0;
		pop_d1 = 1'b0;
		link_up_test();
		routing_test();
		backpressure_test();
		threshold_test();
		error_test();
		$display("tests: %0d ok, %0d failed, %0d errors", pass_tests, fail_tests, err_count);
		if (fail_tests == 0 && err_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// bound on the whole run
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog: run exceeded %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
